//--- slurm16_cfg.svh
`ifndef SLURM16_CFG_SVH
`define SLURM16_CFG_SVH

// Instruction word width
`define SLURM16_BITS 16

// Byte address width
// Fetch works on word addresses, one bit narrower
`define SLURM16_ADDR_BITS 16

// Register index width used for hazard tracking
`define SLURM16_REG_BITS 4

`endif

//--- slurm16_pkg.sv
`include "slurm16_cfg.svh"

package slurm16_pkg;

	typedef logic [`SLURM16_BITS - 1:0] instr_t;
	typedef logic [`SLURM16_ADDR_BITS - 2:0] pc_t;		// Word address
	typedef logic [`SLURM16_ADDR_BITS - 1:0] byte_addr_t;
	typedef logic [`SLURM16_REG_BITS - 1:0] reg_idx_t;

	typedef enum logic [3:0] {
		st_reset,
		st_pre_execute,
		st_execute,
		st_stall1,
		st_stall2,
		st_stall3,
		st_ins_stall1,	// PC rewinds after a miss
		st_ins_stall2,	// Wait for memory
		st_halt,
		st_halt2
	} pipe_state_t;

	typedef enum logic [2:0] {
		pc_clear,
		pc_hold,
		pc_incr,
		pc_rewind,
		pc_branch,
		pc_resume
	} pc_op_t;

endpackage

//--- slurm16_pipeline_ctrl.sv
`include "slurm16_cfg.svh"

module slurm16_pipeline_ctrl (
	input  logic CLK,
	input  logic RSTb,
	input  logic instruction_valid,
	input  logic hazard_1,
	input  logic hazard_2,
	input  logic hazard_3,
	input  logic load_pc_request,
	input  logic halt_request,
	input  logic interrupt_req,
	input  logic nop0,
	input  logic nop1,
	input  logic nop2,
	input  logic nop3,
	output logic instruction_request,
	output slurm16_pkg::pc_op_t pc_op,
	output logic flush0,
	output logic flush1,
	output logic flush2,
	output logic flush3,
	output logic flush4,
	output logic hold1
);

	slurm16_pkg::pipe_state_t state_r;
	logic halt_lat_r;
	logic halt;
	logic stall1_go;
	logic stall2_go;
	logic stall3_go;
	logic hazard_stall;
	logic in_stall;
	logic idle_st;
	logic refill_st;
	logic kill_young;

	// A hazard only counts when both slots hold live instructions
	assign stall1_go = hazard_1 && !load_pc_request && !nop0 && !nop1;
	assign stall2_go = hazard_2 && !load_pc_request && !nop0 && !nop2;
	assign stall3_go = hazard_3 && !load_pc_request && !nop0 && !nop3;
	assign hazard_stall = stall1_go || stall2_go || stall3_go;

	assign halt = halt_lat_r || halt_request;

	assign in_stall = (state_r == slurm16_pkg::st_stall1) ||
		(state_r == slurm16_pkg::st_stall2) || (state_r == slurm16_pkg::st_stall3);
	assign idle_st = (state_r == slurm16_pkg::st_reset) ||
		(state_r == slurm16_pkg::st_halt) || (state_r == slurm16_pkg::st_halt2);
	assign refill_st = idle_st || (state_r == slurm16_pkg::st_pre_execute);
	assign kill_young = load_pc_request || halt;	// Younger than execute slot

	// Memory is left free while sleeping
	assign instruction_request = (state_r != slurm16_pkg::st_halt) &&
		(state_r != slurm16_pkg::st_halt2);

	assign flush0 = (state_r != slurm16_pkg::st_execute) || kill_young;
	assign flush1 = refill_st || (state_r == slurm16_pkg::st_ins_stall1) || kill_young;
	assign flush2 = refill_st || in_stall || kill_young;
	assign flush3 = idle_st;
	assign flush4 = idle_st;
	assign hold1 = in_stall;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_r <= slurm16_pkg::st_reset;
		end else begin
			case (state_r)
				slurm16_pkg::st_reset:
					state_r <= slurm16_pkg::st_pre_execute;
				slurm16_pkg::st_pre_execute:
					state_r <= slurm16_pkg::st_execute;
				slurm16_pkg::st_execute: begin
					// Hazards first, then halt, branch and miss
					if (stall1_go)
						state_r <= slurm16_pkg::st_stall1;
					else if (stall2_go)
						state_r <= slurm16_pkg::st_stall2;
					else if (stall3_go)
						state_r <= slurm16_pkg::st_stall3;
					else if (halt && !load_pc_request)
						state_r <= slurm16_pkg::st_halt;
					else if (load_pc_request)
						state_r <= slurm16_pkg::st_pre_execute;
					else if (!instruction_valid)
						state_r <= slurm16_pkg::st_ins_stall1;
				end
				slurm16_pkg::st_stall1:
					state_r <= load_pc_request ? slurm16_pkg::st_pre_execute :
						slurm16_pkg::st_stall2;
				slurm16_pkg::st_stall2:
					state_r <= load_pc_request ? slurm16_pkg::st_pre_execute :
						slurm16_pkg::st_stall3;
				slurm16_pkg::st_stall3:
					state_r <= load_pc_request ? slurm16_pkg::st_pre_execute :
						slurm16_pkg::st_execute;
				slurm16_pkg::st_ins_stall1:
					state_r <= load_pc_request ? slurm16_pkg::st_pre_execute :
						slurm16_pkg::st_ins_stall2;
				slurm16_pkg::st_ins_stall2: begin
					if (load_pc_request)
						state_r <= slurm16_pkg::st_pre_execute;
					else if (instruction_valid)
						state_r <= slurm16_pkg::st_execute;
				end
				slurm16_pkg::st_halt:
					state_r <= slurm16_pkg::st_halt2;
				slurm16_pkg::st_halt2:
					if (interrupt_req)
						state_r <= slurm16_pkg::st_pre_execute;	// Wake up
				default:
					state_r <= slurm16_pkg::st_reset;
			endcase
		end
	end

	// Sleep is a pulse so keep it until the halt state is reached
	always_ff @(posedge CLK) begin
		if (!RSTb)
			halt_lat_r <= 1'b0;
		else if (state_r == slurm16_pkg::st_halt)
			halt_lat_r <= 1'b0;
		else if (halt_request)
			halt_lat_r <= 1'b1;
	end

	always_comb begin
		pc_op = slurm16_pkg::pc_hold;
		case (state_r)
			slurm16_pkg::st_reset:
				pc_op = slurm16_pkg::pc_clear;
			slurm16_pkg::st_pre_execute:
				pc_op = slurm16_pkg::pc_incr;
			slurm16_pkg::st_execute:
				if (load_pc_request)
					pc_op = slurm16_pkg::pc_branch;
				else if (hazard_stall || !instruction_valid)
					pc_op = slurm16_pkg::pc_rewind;	// Refetch the dropped word
				else
					pc_op = slurm16_pkg::pc_incr;
			slurm16_pkg::st_stall1, slurm16_pkg::st_stall2, slurm16_pkg::st_ins_stall1:
				if (load_pc_request)
					pc_op = slurm16_pkg::pc_branch;
			slurm16_pkg::st_stall3:
				pc_op = load_pc_request ? slurm16_pkg::pc_branch : slurm16_pkg::pc_incr;
			slurm16_pkg::st_ins_stall2:
				if (load_pc_request)
					pc_op = slurm16_pkg::pc_branch;
				else if (instruction_valid)
					pc_op = slurm16_pkg::pc_incr;
			slurm16_pkg::st_halt:
				pc_op = slurm16_pkg::pc_resume;
			default: ;
		endcase
	end

endmodule

//--- slurm16_pc_unit.sv
`include "slurm16_cfg.svh"

module slurm16_pc_unit (
	input  logic CLK,
	input  slurm16_pkg::pc_op_t pc_op,
	input  slurm16_pkg::byte_addr_t load_pc_address,
	input  logic halt_request,
	input  slurm16_pkg::pc_t pc_stage_2,
	output slurm16_pkg::pc_t instruction_address
);

	slurm16_pkg::pc_t pc_r;		// Address being fetched
	slurm16_pkg::pc_t prev_pc_r;	// Address fetched one cycle earlier
	slurm16_pkg::pc_t halt_pc_r;
	slurm16_pkg::pc_t branch_pc;

	// Branch targets are byte addresses
	assign branch_pc = load_pc_address[`SLURM16_ADDR_BITS - 1:1];

	assign instruction_address = pc_r;

	// Sleep sits in execute so the core resumes one word past it
	always_ff @(posedge CLK) begin
		if (halt_request)
			halt_pc_r <= pc_stage_2 + slurm16_pkg::pc_t'(1);
	end

	always_ff @(posedge CLK) begin
		case (pc_op)
			slurm16_pkg::pc_clear: begin
				pc_r <= '0;
				prev_pc_r <= '0;
			end
			slurm16_pkg::pc_incr: begin
				pc_r <= pc_r + slurm16_pkg::pc_t'(1);
				prev_pc_r <= pc_r;
			end
			slurm16_pkg::pc_rewind: begin
				// The word behind prev_pc_r was lost or must wait
				pc_r <= prev_pc_r;
			end
			slurm16_pkg::pc_branch: begin
				pc_r <= branch_pc;
				prev_pc_r <= branch_pc;
			end
			slurm16_pkg::pc_resume: begin
				pc_r <= halt_pc_r;
				prev_pc_r <= halt_pc_r;
			end
			default: ;	// pc_hold
		endcase
	end

endmodule

//--- slurm16_stage_regs.sv
`include "slurm16_cfg.svh"

module slurm16_stage_regs (
	input  logic CLK,
	input  slurm16_pkg::instr_t instruction_in,
	input  slurm16_pkg::pc_t instruction_address_in,
	input  slurm16_pkg::reg_idx_t hazard_reg0,
	input  logic modifies_flags0,
	input  logic flush0,
	input  logic flush1,
	input  logic flush2,
	input  logic flush3,
	input  logic flush4,
	input  logic hold1,
	output slurm16_pkg::instr_t pipeline_stage_0,
	output slurm16_pkg::instr_t pipeline_stage_1,
	output slurm16_pkg::instr_t pipeline_stage_2,
	output slurm16_pkg::instr_t pipeline_stage_3,
	output slurm16_pkg::instr_t pipeline_stage_4,
	output slurm16_pkg::pc_t pc_stage_2,
	output slurm16_pkg::byte_addr_t pc_stage_4,
	output logic nop0,
	output logic nop1,
	output logic nop2,
	output logic nop3,
	output logic nop4,
	output slurm16_pkg::reg_idx_t hazard_reg1,
	output slurm16_pkg::reg_idx_t hazard_reg2,
	output slurm16_pkg::reg_idx_t hazard_reg3,
	output logic modifies_flags1,
	output logic modifies_flags2,
	output logic modifies_flags3
);

	// Stage 0 fetch, 1 decode, 2 execute, 3 memory, 4 writeback
	slurm16_pkg::instr_t ins_r [0:4];
	slurm16_pkg::pc_t addr_r [0:4];
	logic [4:0] nop_r;
	slurm16_pkg::reg_idx_t haz_r [1:3];	// Hazard info needed only up to memory
	logic [3:1] mf_r;
	logic [4:0] flush;

	assign flush = {flush4, flush3, flush2, flush1, flush0};

	always_ff @(posedge CLK) begin
		// Fetch slot takes whatever memory returned
		ins_r[0] <= instruction_in;
		addr_r[0] <= instruction_address_in;
		nop_r[0] <= flush[0];

		// Decode slot freezes during hazard stalls
		if (!hold1) begin
			ins_r[1] <= ins_r[0];
			addr_r[1] <= addr_r[0];
			haz_r[1] <= hazard_reg0;	// Decoded outside from stage 0
			mf_r[1] <= modifies_flags0;
			nop_r[1] <= nop_r[0];
		end
		if (flush[1])
			nop_r[1] <= 1'b1;		// Wins over a hold

		for (int i = 2; i < 5; i++) begin
			ins_r[i] <= ins_r[i - 1];
			addr_r[i] <= addr_r[i - 1];
			nop_r[i] <= flush[i] || nop_r[i - 1];
		end

		for (int i = 2; i < 4; i++) begin
			haz_r[i] <= haz_r[i - 1];
			mf_r[i] <= mf_r[i - 1];
		end
	end

	assign pipeline_stage_0 = ins_r[0];
	assign pipeline_stage_1 = ins_r[1];
	assign pipeline_stage_2 = ins_r[2];
	assign pipeline_stage_3 = ins_r[3];
	assign pipeline_stage_4 = ins_r[4];

	assign pc_stage_2 = addr_r[2];
	assign pc_stage_4 = {addr_r[4], 1'b0};	// Back to a byte address

	assign nop0 = nop_r[0];
	assign nop1 = nop_r[1];
	assign nop2 = nop_r[2];
	assign nop3 = nop_r[3];
	assign nop4 = nop_r[4];

	assign hazard_reg1 = haz_r[1];
	assign hazard_reg2 = haz_r[2];
	assign hazard_reg3 = haz_r[3];
	assign modifies_flags1 = mf_r[1];
	assign modifies_flags2 = mf_r[2];
	assign modifies_flags3 = mf_r[3];

endmodule

//--- slurm16_pipeline.sv
`include "slurm16_cfg.svh"

module slurm16_pipeline (
	input  logic CLK,
	input  logic RSTb,
	output logic instruction_request,
	input  logic instruction_valid,		// Low on a fetch miss
	output slurm16_pkg::pc_t instruction_address,
	input  slurm16_pkg::instr_t instruction_in,
	input  slurm16_pkg::pc_t instruction_address_in,
	output slurm16_pkg::instr_t pipeline_stage_0,
	output slurm16_pkg::instr_t pipeline_stage_1,
	output slurm16_pkg::instr_t pipeline_stage_2,
	output slurm16_pkg::instr_t pipeline_stage_3,
	output slurm16_pkg::instr_t pipeline_stage_4,
	output slurm16_pkg::byte_addr_t pc_stage_4,
	output logic nop_stage_2,		// Execute must not change state
	output logic nop_stage_4,		// No writeback
	input  logic hazard_1,
	input  logic hazard_2,
	input  logic hazard_3,
	input  slurm16_pkg::reg_idx_t hazard_reg0,
	input  logic modifies_flags0,
	output slurm16_pkg::reg_idx_t hazard_reg1,
	output slurm16_pkg::reg_idx_t hazard_reg2,
	output slurm16_pkg::reg_idx_t hazard_reg3,
	output logic modifies_flags1,
	output logic modifies_flags2,
	output logic modifies_flags3,
	input  logic halt_request,
	input  logic interrupt_req,		// Wakes the core from halt
	input  logic load_pc_request,
	input  slurm16_pkg::byte_addr_t load_pc_address
);

	slurm16_pkg::pc_op_t pc_op;
	slurm16_pkg::pc_t pc_stage_2;
	logic flush0;
	logic flush1;
	logic flush2;
	logic flush3;
	logic flush4;
	logic hold1;
	logic nop0;
	logic nop1;
	logic nop3;

	slurm16_pipeline_ctrl slurm16_pipeline_ctrl_inst (
		.CLK(CLK),
		.RSTb(RSTb),
		.instruction_valid(instruction_valid),
		.hazard_1(hazard_1),
		.hazard_2(hazard_2),
		.hazard_3(hazard_3),
		.load_pc_request(load_pc_request),
		.halt_request(halt_request),
		.interrupt_req(interrupt_req),
		.nop0(nop0),
		.nop1(nop1),
		.nop2(nop_stage_2),
		.nop3(nop3),
		.instruction_request(instruction_request),
		.pc_op(pc_op),
		.flush0(flush0),
		.flush1(flush1),
		.flush2(flush2),
		.flush3(flush3),
		.flush4(flush4),
		.hold1(hold1)
	);

	slurm16_pc_unit slurm16_pc_unit_inst (
		.CLK(CLK),
		.pc_op(pc_op),
		.load_pc_address(load_pc_address),
		.halt_request(halt_request),
		.pc_stage_2(pc_stage_2),
		.instruction_address(instruction_address)
	);

	slurm16_stage_regs slurm16_stage_regs_inst (
		.CLK(CLK),
		.instruction_in(instruction_in),
		.instruction_address_in(instruction_address_in),
		.hazard_reg0(hazard_reg0),
		.modifies_flags0(modifies_flags0),
		.flush0(flush0),
		.flush1(flush1),
		.flush2(flush2),
		.flush3(flush3),
		.flush4(flush4),
		.hold1(hold1),
		.pipeline_stage_0(pipeline_stage_0),
		.pipeline_stage_1(pipeline_stage_1),
		.pipeline_stage_2(pipeline_stage_2),
		.pipeline_stage_3(pipeline_stage_3),
		.pipeline_stage_4(pipeline_stage_4),
		.pc_stage_2(pc_stage_2),
		.pc_stage_4(pc_stage_4),
		.nop0(nop0),
		.nop1(nop1),
		.nop2(nop_stage_2),
		.nop3(nop3),
		.nop4(nop_stage_4),
		.hazard_reg1(hazard_reg1),
		.hazard_reg2(hazard_reg2),
		.hazard_reg3(hazard_reg3),
		.modifies_flags1(modifies_flags1),
		.modifies_flags2(modifies_flags2),
		.modifies_flags3(modifies_flags3)
	);

endmodule

//--- slurm16_pipeline_asserts.sv
module slurm16_pipeline_asserts (
	input  logic CLK,
	input  logic RSTb,
	input  logic instruction_request,
	input  logic halt_request,
	input  logic interrupt_req,
	input  slurm16_pkg::instr_t pipeline_stage_0,
	input  slurm16_pkg::instr_t pipeline_stage_1,
	input  slurm16_pkg::instr_t pipeline_stage_2,
	input  slurm16_pkg::instr_t pipeline_stage_3,
	input  slurm16_pkg::instr_t pipeline_stage_4,
	input  slurm16_pkg::byte_addr_t pc_stage_4,
	input  logic nop_stage_2,
	input  logic nop_stage_4
);

	logic [2:0] settle_r;	// Stage registers fill a few cycles after reset
	logic halt_seen_r;

	always_ff @(posedge CLK) begin
		if (!RSTb)
			settle_r <= 3'd0;
		else if (settle_r != 3'd7)
			settle_r <= settle_r + 3'd1;
	end

	// Sleeping from halt request until the wake-up
	always_ff @(posedge CLK) begin
		if (!RSTb)
			halt_seen_r <= 1'b0;
		else if (halt_request)
			halt_seen_r <= 1'b1;
		else if (interrupt_req)
			halt_seen_r <= 1'b0;
	end

	stage_known: assert property (@(posedge CLK) disable iff (!RSTb)
		(settle_r == 3'd7) |-> !$isunknown({pipeline_stage_0, pipeline_stage_1,
		pipeline_stage_2, pipeline_stage_3, pipeline_stage_4, pc_stage_4,
		nop_stage_2, nop_stage_4}))
		else $error("stage output unknown after reset");

	request_low_only_halted: assert property (@(posedge CLK) disable iff (!RSTb)
		!instruction_request |-> halt_seen_r)
		else $error("instruction_request low without a halt");

endmodule

//--- tb_slurm16_pipeline.sv
module tb_slurm16_pipeline;

	localparam int wait_limit = 600;	// Cycles allowed for any single wait
	localparam int min_retired = 200;

	logic CLK;
	logic RSTb;
	logic instruction_request;
	logic instruction_valid;
	slurm16_pkg::pc_t instruction_address;
	slurm16_pkg::instr_t instruction_in;
	slurm16_pkg::pc_t instruction_address_in;
	slurm16_pkg::instr_t pipeline_stage_0;
	slurm16_pkg::instr_t pipeline_stage_1;
	slurm16_pkg::instr_t pipeline_stage_2;
	slurm16_pkg::instr_t pipeline_stage_3;
	slurm16_pkg::instr_t pipeline_stage_4;
	slurm16_pkg::byte_addr_t pc_stage_4;
	logic nop_stage_2;
	logic nop_stage_4;
	logic hazard_1;
	logic hazard_2;
	logic hazard_3;
	slurm16_pkg::reg_idx_t hazard_reg0;
	logic modifies_flags0;
	slurm16_pkg::reg_idx_t hazard_reg1;
	slurm16_pkg::reg_idx_t hazard_reg2;
	slurm16_pkg::reg_idx_t hazard_reg3;
	logic modifies_flags1;
	logic modifies_flags2;
	logic modifies_flags3;
	logic halt_request;
	logic interrupt_req;
	logic load_pc_request;
	slurm16_pkg::byte_addr_t load_pc_address;

	// Instruction memory read port
	slurm16_pkg::instr_t mem_word;
	slurm16_pkg::pc_t mem_addr;

	// Retire checker state
	logic checking;
	slurm16_pkg::byte_addr_t expect_addr;
	logic redirect_pending;
	slurm16_pkg::byte_addr_t redirect_from;	// Last address before the jump
	slurm16_pkg::byte_addr_t redirect_to;
	int retired;

	slurm16_pipeline slurm16_pipeline_inst (.*);

	bind slurm16_pipeline slurm16_pipeline_asserts slurm16_pipeline_asserts_inst (.*);

	always #50 CLK = ~CLK;

	// Instruction memory answers one cycle later, word A reads as A with the top bit set
	always @(posedge CLK) begin
		mem_word <= {1'b1, instruction_address};
		mem_addr <= instruction_address;
	end

	// A miss returns a word that must never retire
	assign instruction_in = instruction_valid ? mem_word : '0;
	assign instruction_address_in = instruction_valid ? mem_addr : '0;

	assign hazard_reg0 = pipeline_stage_0[3:0];	// Decoded register of the fetch slot
	assign modifies_flags0 = pipeline_stage_0[4];

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error: time %0t signal %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	always @(negedge CLK) begin
		if (checking) begin
			if (!nop_stage_4) begin
				check_value("pc_stage_4", pc_stage_4, expect_addr);
				check_value("pipeline_stage_4", pipeline_stage_4, {1'b1, expect_addr[15:1]});
				if (redirect_pending && expect_addr == redirect_from) begin
					expect_addr = redirect_to;
					redirect_pending = 1'b0;
				end else begin
					expect_addr = expect_addr + 16'd2;
				end
				retired++;
			end
			if (retired > 0) begin
				// Hazard info travels with its instruction
				check_value("hazard_reg1", hazard_reg1, pipeline_stage_1[3:0]);
				check_value("hazard_reg2", hazard_reg2, pipeline_stage_2[3:0]);
				check_value("hazard_reg3", hazard_reg3, pipeline_stage_3[3:0]);
				check_value("modifies_flags1", modifies_flags1, pipeline_stage_1[4]);
				check_value("modifies_flags2", modifies_flags2, pipeline_stage_2[4]);
				check_value("modifies_flags3", modifies_flags3, pipeline_stage_3[4]);
			end
		end
	end

	// Returns on the rising edge that moves the word from decode to execute
	task automatic wait_decode(input int word);
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (pipeline_stage_1 !== {1'b1, slurm16_pkg::pc_t'(word)}) begin
			cycles++;
			if (cycles > wait_limit) begin
				$display("timeout while waiting for word %h to reach decode", word);
				stop_run();
			end
			@(negedge CLK);
		end
		@(posedge CLK);
	endtask

	task automatic confirm_execute(input int word);
		@(negedge CLK);
		check_value("nop_stage_2", nop_stage_2, 0);
		check_value("pipeline_stage_2", pipeline_stage_2, {1'b1, slurm16_pkg::pc_t'(word)});
		@(posedge CLK);
	endtask

	// Counts the empty execute slots that follow a hazard
	task automatic check_bubbles(input int expected);
		int bubbles;
		bubbles = 0;
		@(negedge CLK);	// Younger word still moves on
		@(negedge CLK);
		while (nop_stage_2 === 1'b1) begin
			bubbles++;
			if (bubbles > wait_limit) begin
				$display("timeout while the execute slot stayed empty");
				stop_run();
			end
			@(negedge CLK);
		end
		check_value("nop_stage_2 cycles", bubbles, expected);
	endtask

	task automatic wait_request(input logic level);
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (instruction_request !== level) begin
			cycles++;
			if (cycles > wait_limit) begin
				$display("timeout while waiting for instruction_request to become %b", level);
				stop_run();
			end
			@(negedge CLK);
		end
	endtask

	task automatic run_command(input string cmd, input int count, input int word,
			input int target);
		int len;
		case (cmd)
			"run": repeat (count) @(posedge CLK);
			"branch": begin
				wait_decode(word);
				load_pc_request <= 1'b1;
				load_pc_address <= slurm16_pkg::byte_addr_t'(target);
				redirect_from = slurm16_pkg::byte_addr_t'(word * 2);
				redirect_to = slurm16_pkg::byte_addr_t'(target);
				redirect_pending = 1'b1;
				confirm_execute(word);
				load_pc_request <= 1'b0;
			end
			"hazard": begin
				wait_decode(word);
				hazard_1 <= (count == 1);
				hazard_2 <= (count == 2);
				hazard_3 <= (count == 3);
				confirm_execute(word);
				hazard_1 <= 1'b0;
				hazard_2 <= 1'b0;
				hazard_3 <= 1'b0;
				check_bubbles(4 - count);	// One per stall state from k to 3
			end
			"miss": begin
				for (int i = 0; i < count; i++) begin
					len = ($urandom % 4) + 1;
					@(posedge CLK);
					instruction_valid <= 1'b0;
					repeat (len) @(posedge CLK);
					instruction_valid <= 1'b1;
					repeat (12) @(posedge CLK);
				end
			end
			"halt": begin
				wait_decode(word);
				halt_request <= 1'b1;
				redirect_from = slurm16_pkg::byte_addr_t'((word - 1) * 2);	// Sleep never retires
				redirect_to = slurm16_pkg::byte_addr_t'(target);
				redirect_pending = 1'b1;
				confirm_execute(word);
				halt_request <= 1'b0;
			end
			"wake": begin
				wait_request(1'b0);
				repeat (count) begin
					@(negedge CLK);
					check_value("instruction_request", instruction_request, 0);
				end
				@(posedge CLK);
				interrupt_req <= 1'b1;
				@(posedge CLK);
				interrupt_req <= 1'b0;
				wait_request(1'b1);
			end
			default: begin
				$display("unknown trace command %s", cmd);
				stop_run();
			end
		endcase
	endtask

	initial begin
		int fd;
		string line;
		string cmd;
		int count;
		int word;
		int target;
		void'($urandom(32'h4b9e_2b8b));
		CLK = 1'b0;
		RSTb = 1'b0;
		instruction_valid = 1'b1;
		mem_word = '0;
		mem_addr = '0;
		hazard_1 = 1'b0;
		hazard_2 = 1'b0;
		hazard_3 = 1'b0;
		halt_request = 1'b0;
		interrupt_req = 1'b0;
		load_pc_request = 1'b0;
		load_pc_address = '0;
		checking = 1'b0;
		expect_addr = '0;
		redirect_pending = 1'b0;
		redirect_from = '0;
		redirect_to = '0;
		retired = 0;

		fd = $fopen("slurm16_pipeline_trace.txt", "r");
		if (fd == 0) begin
			$display("the trace file could not be opened");
			stop_run();
		end

		repeat (3) @(posedge CLK);
		RSTb <= 1'b1;
		checking = 1'b1;
		@(negedge CLK);
		check_value("nop_stage_2", nop_stage_2, 1);
		check_value("nop_stage_4", nop_stage_4, 1);
		check_value("instruction_request", instruction_request, 1);

		while ($fgets(line, fd) != 0) begin
			if ($sscanf(line, "%s %d %h %h", cmd, count, word, target) == 4)
				run_command(cmd, count, word, target);	// Comment lines do not parse
		end
		$fclose(fd);
		repeat (20) @(posedge CLK);

		if (retired < min_retired) begin
			$display("only %0d instructions retired", retired);
			stop_run();
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

//--- slurm16_pipeline_trace.txt
# command count word_address expected_byte_address
# count in decimal, addresses in hex; branch and halt give the next retired address
run 12 0 0
branch 0 0010 0040
run 12 0 0
hazard 1 0040 0
run 12 0 0
hazard 2 0060 0
run 12 0 0
hazard 3 0080 0
run 12 0 0
miss 4 0 0
run 12 0 0
halt 0 0100 0202
wake 8 0 0
run 16 0 0
branch 0 0110 0006
run 12 0 0
hazard 1 0020 0
run 20 0 0

//--- compile.f
+incdir+.
slurm16_pkg.sv
slurm16_pipeline_ctrl.sv
slurm16_pc_unit.sv
slurm16_stage_regs.sv
slurm16_pipeline.sv
slurm16_pipeline_asserts.sv
tb_slurm16_pipeline.sv

//--- Bender.yml
package:
  name: slurm16_pipeline

sources:
  - include_dirs:
      - .
    files:
      - slurm16_pkg.sv
      - slurm16_pipeline_ctrl.sv
      - slurm16_pc_unit.sv
      - slurm16_stage_regs.sv
      - slurm16_pipeline.sv
      - target: test
        files:
          - slurm16_pipeline_asserts.sv
          - tb_slurm16_pipeline.sv
